/* verilog/soc_pkg.sv */
package soc_pkg;

    // ====================
    // Bus and pin types
    // ====================

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_sel_t;

    localparam int GPIO_PINS = 8;
    localparam int PWM_PIN   = 7;

    typedef logic [GPIO_PINS-1:0] gpio_t;

    // Load/store width in RISC-V funct3 encoding
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_op_e;

    // ====================
    // Address map
    // ====================

    localparam int    DMEM_WORDS = 1024;
    localparam int    DMEM_AW    = $clog2(DMEM_WORDS) + 2;
    localparam addr_t DMEM_BASE  = 32'h0000_0000;
    localparam addr_t GPIO_BASE  = 32'h2000_0000;
    localparam addr_t PWM_BASE   = 32'h2000_0100;

    // 16-byte register windows
    localparam int REG_AW = 4;
    typedef logic [REG_AW-1:0] reg_ofs_t;

    localparam reg_ofs_t GPIO_OUT_OFS   = 4'h0;
    localparam reg_ofs_t GPIO_OE_OFS    = 4'h4;
    localparam reg_ofs_t GPIO_IN_OFS    = 4'h8;
    localparam reg_ofs_t GPIO_SEL_OFS   = 4'hC;

    localparam reg_ofs_t PWM_PERIOD_OFS = 4'h0;
    localparam reg_ofs_t PWM_DUTY_OFS   = 4'h4;
    localparam reg_ofs_t PWM_CTRL_OFS   = 4'h8;
    localparam reg_ofs_t PWM_COUNT_OFS  = 4'hC;

endpackage : soc_pkg

/* verilog/bus_master.sv */
`timescale 1ns/1ps

module bus_master (
    input  logic               clk,
    input  logic               reset_n,

    // Processor request
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  soc_pkg::addr_t     req_addr_i,
    input  soc_pkg::data_t     req_wdata_i,
    input  logic               req_write_i,
    input  soc_pkg::mem_op_e   req_op_i,

    // Processor response
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output soc_pkg::data_t     resp_rdata_o,
    output logic               resp_err_o,

    // Bus side
    output soc_pkg::addr_t     wb_adr_o,
    output soc_pkg::data_t     wb_dat_o,
    output soc_pkg::byte_sel_t wb_sel_o,
    output logic               wb_we_o,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    input  soc_pkg::data_t     wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_e;

    state_e    state;
    logic      cyc_q;
    mem_op_e   op_q;
    logic      misaligned;
    byte_sel_t sel_next;
    data_t     wdata_next;
    data_t     lane;
    data_t     load_data;

    assign req_ready_o = (state == ST_IDLE);
    assign wb_cyc_o    = cyc_q;
    assign wb_stb_o    = cyc_q;

    // Alignment check and lane steering for the incoming request
    always_comb begin
        misaligned = 1'b0;
        sel_next   = 4'b1111;
        wdata_next = req_wdata_i;
        case (req_op_i)
            MEM_B, MEM_BU: begin
                sel_next   = 4'b0001 << req_addr_i[1:0];
                wdata_next = {4{req_wdata_i[7:0]}};
            end
            MEM_H, MEM_HU: begin
                misaligned = req_addr_i[0];
                sel_next   = 4'b0011 << {req_addr_i[1], 1'b0};
                wdata_next = {2{req_wdata_i[15:0]}};
            end
            default: misaligned = |req_addr_i[1:0];
        endcase
    end

    // Pick the addressed lane and extend it
    always_comb begin
        lane = wb_dat_i >> {wb_adr_o[1:0], 3'b000};
        case (op_q)
            MEM_B:   load_data = {{24{lane[7]}}, lane[7:0]};
            MEM_BU:  load_data = {24'b0, lane[7:0]};
            MEM_H:   load_data = {{16{lane[15]}}, lane[15:0]};
            MEM_HU:  load_data = {16'b0, lane[15:0]};
            default: load_data = lane;
        endcase
    end

    // ====================
    // Cycle control
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= ST_IDLE;
            cyc_q        <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        if (misaligned) begin
                            resp_valid_o <= 1'b1;
                            state        <= ST_RESP;
                        end else begin
                            cyc_q <= 1'b1;
                            state <= ST_BUS;
                        end
                    end
                end
                ST_BUS: begin
                    if (wb_ack_i) begin
                        cyc_q        <= 1'b0;
                        resp_valid_o <= 1'b1;
                        state        <= ST_RESP;
                    end
                end
                default: begin
                    // Response held until taken
                    if (resp_ready_i) begin
                        resp_valid_o <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid_i) begin
            wb_adr_o <= req_addr_i;
            wb_dat_o <= wdata_next;
            wb_sel_o <= sel_next;
            wb_we_o  <= req_write_i;
            op_q     <= req_op_i;
            if (misaligned) begin
                resp_rdata_o <= '0;
                resp_err_o   <= 1'b1;
            end
        end
        if (state == ST_BUS && wb_ack_i) begin
            resp_rdata_o <= (wb_we_o || wb_err_i) ? '0 : load_data;
            resp_err_o   <= wb_err_i;
        end
    end

endmodule : bus_master

/* verilog/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
    input  logic           clk,
    input  logic           reset_n,

    // From the master
    input  soc_pkg::addr_t wb_adr_i,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    output soc_pkg::data_t wb_dat_o,
    output logic           wb_ack_o,
    output logic           wb_err_o,

    // Data RAM
    output logic           ram_stb_o,
    input  soc_pkg::data_t ram_dat_i,
    input  logic           ram_ack_i,

    // GPIO
    output logic           gpio_stb_o,
    input  soc_pkg::data_t gpio_dat_i,
    input  logic           gpio_ack_i,

    // PWM
    output logic           pwm_stb_o,
    input  soc_pkg::data_t pwm_dat_i,
    input  logic           pwm_ack_i
);
    import soc_pkg::*;

    logic ram_hit;
    logic gpio_hit;
    logic pwm_hit;
    logic req;
    logic err_ack;

    assign req = wb_cyc_i & wb_stb_i;

    // Window match on upper address bits
    assign ram_hit  = (wb_adr_i[31:DMEM_AW] == DMEM_BASE[31:DMEM_AW]);
    assign gpio_hit = (wb_adr_i[31:REG_AW] == GPIO_BASE[31:REG_AW]);
    assign pwm_hit  = (wb_adr_i[31:REG_AW] == PWM_BASE[31:REG_AW]);

    assign ram_stb_o  = req & ram_hit;
    assign gpio_stb_o = req & gpio_hit;
    assign pwm_stb_o  = req & pwm_hit;

    // Unmapped address answers like a slave, one cycle later
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            err_ack <= 1'b0;
        end else begin
            err_ack <= req & ~(ram_hit | gpio_hit | pwm_hit) & ~err_ack;
        end
    end

    assign wb_ack_o = ram_ack_i | gpio_ack_i | pwm_ack_i | err_ack;
    assign wb_err_o = err_ack;

    // ====================
    // Read data return
    // ====================

    always_comb begin
        if (ram_ack_i) begin
            wb_dat_o = ram_dat_i;
        end else if (gpio_ack_i) begin
            wb_dat_o = gpio_dat_i;
        end else if (pwm_ack_i) begin
            wb_dat_o = pwm_dat_i;
        end else begin
            wb_dat_o = '0;
        end
    end

endmodule : bus_decoder

/* verilog/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               stb_i,
    input  logic               we_i,
    input  soc_pkg::addr_t     adr_i,
    input  soc_pkg::byte_sel_t sel_i,
    input  soc_pkg::data_t     dat_i,
    output soc_pkg::data_t     dat_o,
    output logic               ack_o
);
    import soc_pkg::*;

    data_t                  mem [DMEM_WORDS];
    logic [DMEM_AW-3:0]     word_idx;
    logic                   access;

    assign word_idx = adr_i[DMEM_AW-1:2];
    // Single access per strobe
    assign access = stb_i & ~ack_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    // Byte-masked write, registered read
    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel_i[i]) begin
                        mem[word_idx][8*i +: 8] <= dat_i[8*i +: 8];
                    end
                end
            end
            dat_o <= mem[word_idx];
        end
    end

endmodule : data_ram

/* verilog/gpio_ctrl.sv */
`timescale 1ns/1ps

module gpio_ctrl (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               stb_i,
    input  logic               we_i,
    input  soc_pkg::addr_t     adr_i,
    input  soc_pkg::byte_sel_t sel_i,
    input  soc_pkg::data_t     dat_i,
    output soc_pkg::data_t     dat_o,
    output logic               ack_o,

    // Shared pad source
    input  logic               pwm_i,

    // Pads
    input  soc_pkg::gpio_t     gpio_i,
    output soc_pkg::gpio_t     gpio_o,
    output soc_pkg::gpio_t     gpio_en_o
);
    import soc_pkg::*;

    gpio_t    out_q;
    gpio_t    oe_q;
    logic     pwm_sel_q;
    gpio_t    sync_q1;
    gpio_t    sync_q2;
    gpio_t    in_q;
    reg_ofs_t ofs;
    logic     access;
    logic     wr;

    assign ofs    = adr_i[REG_AW-1:0];
    assign access = stb_i & ~ack_o;
    // Registers live in byte lane 0
    assign wr     = access & we_i & sel_i[0];

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_q     <= '0;
            oe_q      <= '0;
            pwm_sel_q <= 1'b0;
            sync_q1   <= '0;
            sync_q2   <= '0;
            in_q      <= '0;
            ack_o     <= 1'b0;
        end else begin
            sync_q1 <= gpio_i;
            sync_q2 <= sync_q1;
            in_q    <= sync_q2;
            ack_o   <= access;
            if (wr) begin
                case (ofs)
                    GPIO_OUT_OFS: out_q     <= dat_i[GPIO_PINS-1:0];
                    GPIO_OE_OFS:  oe_q      <= dat_i[GPIO_PINS-1:0];
                    GPIO_SEL_OFS: pwm_sel_q <= dat_i[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (ofs)
                GPIO_OUT_OFS: dat_o <= data_t'(out_q);
                GPIO_OE_OFS:  dat_o <= data_t'(oe_q);
                GPIO_IN_OFS:  dat_o <= data_t'(in_q);
                GPIO_SEL_OFS: dat_o <= data_t'(pwm_sel_q);
                default:      dat_o <= '0;
            endcase
        end
    end

    // PWM can take over one pad
    always_comb begin
        gpio_o    = out_q;
        gpio_en_o = oe_q;
        if (pwm_sel_q) begin
            gpio_o[PWM_PIN]    = pwm_i;
            gpio_en_o[PWM_PIN] = 1'b1;
        end
    end

endmodule : gpio_ctrl

/* verilog/pwm_timer.sv */
`timescale 1ns/1ps

module pwm_timer (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           stb_i,
    input  logic           we_i,
    input  soc_pkg::addr_t adr_i,
    input  soc_pkg::data_t dat_i,
    output soc_pkg::data_t dat_o,
    output logic           ack_o,
    output logic           pwm_o
);
    import soc_pkg::*;

    typedef logic [15:0] cnt_t;

    cnt_t     period_q;
    cnt_t     duty_q;
    cnt_t     count_q;
    logic     en_q;
    reg_ofs_t ofs;
    logic     access;
    logic     wr;
    logic     wrap;

    assign ofs    = adr_i[REG_AW-1:0];
    assign access = stb_i & ~ack_o;
    assign wr     = access & we_i;

    // Last count of the period in 17 bits so period 0 holds at 0
    assign wrap = ({1'b0, count_q} + 17'd1) >= {1'b0, period_q};

    // ====================
    // Registers and counter
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            period_q <= '0;
            duty_q   <= '0;
            en_q     <= 1'b0;
            count_q  <= '0;
            ack_o    <= 1'b0;
        end else begin
            ack_o <= access;
            if (wr) begin
                case (ofs)
                    PWM_PERIOD_OFS: period_q <= dat_i[15:0];
                    PWM_DUTY_OFS:   duty_q   <= dat_i[15:0];
                    PWM_CTRL_OFS:   en_q     <= dat_i[0];
                    default: ;
                endcase
            end
            if (!en_q || wrap) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (ofs)
                PWM_PERIOD_OFS: dat_o <= data_t'(period_q);
                PWM_DUTY_OFS:   dat_o <= data_t'(duty_q);
                PWM_CTRL_OFS:   dat_o <= data_t'(en_q);
                default:        dat_o <= data_t'(count_q);
            endcase
        end
    end

    assign pwm_o = en_q & (count_q < duty_q);

endmodule : pwm_timer

/* verilog/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic             clk,
    input  logic             reset_n,

    // Request port
    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  soc_pkg::addr_t   req_addr_i,
    input  soc_pkg::data_t   req_wdata_i,
    input  logic             req_write_i,
    input  soc_pkg::mem_op_e req_op_i,

    // Response port
    output logic             resp_valid_o,
    input  logic             resp_ready_i,
    output soc_pkg::data_t   resp_rdata_o,
    output logic             resp_err_o,

    // Pads
    input  soc_pkg::gpio_t   gpio_i,
    output soc_pkg::gpio_t   gpio_o,
    output soc_pkg::gpio_t   gpio_en_o
);
    import soc_pkg::*;

    addr_t     wb_adr;
    data_t     wb_dat_w;
    byte_sel_t wb_sel;
    logic      wb_we;
    logic      wb_cyc;
    logic      wb_stb;
    data_t     wb_dat_r;
    logic      wb_ack;
    logic      wb_err;

    logic      ram_stb;
    data_t     ram_dat;
    logic      ram_ack;
    logic      gpio_stb;
    data_t     gpio_dat;
    logic      gpio_ack;
    logic      pwm_stb;
    data_t     pwm_dat;
    logic      pwm_ack;
    logic      pwm_out;

    // ====================
    // Master and decode
    // ====================

    bus_master bus_master_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_write_i  (req_write_i),
        .req_op_i     (req_op_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o),
        .resp_err_o   (resp_err_o),
        .wb_adr_o     (wb_adr),
        .wb_dat_o     (wb_dat_w),
        .wb_sel_o     (wb_sel),
        .wb_we_o      (wb_we),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_dat_i     (wb_dat_r),
        .wb_ack_i     (wb_ack),
        .wb_err_i     (wb_err)
    );

    bus_decoder bus_decoder_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .wb_adr_i   (wb_adr),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .wb_err_o   (wb_err),
        .ram_stb_o  (ram_stb),
        .ram_dat_i  (ram_dat),
        .ram_ack_i  (ram_ack),
        .gpio_stb_o (gpio_stb),
        .gpio_dat_i (gpio_dat),
        .gpio_ack_i (gpio_ack),
        .pwm_stb_o  (pwm_stb),
        .pwm_dat_i  (pwm_dat),
        .pwm_ack_i  (pwm_ack)
    );

    // ====================
    // Slaves
    // ====================

    data_ram data_ram_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .stb_i   (ram_stb),
        .we_i    (wb_we),
        .adr_i   (wb_adr),
        .sel_i   (wb_sel),
        .dat_i   (wb_dat_w),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    gpio_ctrl gpio_ctrl_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .stb_i     (gpio_stb),
        .we_i      (wb_we),
        .adr_i     (wb_adr),
        .sel_i     (wb_sel),
        .dat_i     (wb_dat_w),
        .dat_o     (gpio_dat),
        .ack_o     (gpio_ack),
        .pwm_i     (pwm_out),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_en_o (gpio_en_o)
    );

    pwm_timer pwm_timer_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .stb_i   (pwm_stb),
        .we_i    (wb_we),
        .adr_i   (wb_adr),
        .dat_i   (wb_dat_w),
        .dat_o   (pwm_dat),
        .ack_o   (pwm_ack),
        .pwm_o   (pwm_out)
    );

endmodule : soc_top

/* sim/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;
    import soc_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;

    logic     clk;
    logic     reset_n;
    logic     req_valid;
    logic     req_ready;
    addr_t    req_addr;
    data_t    req_wdata;
    logic     req_write;
    mem_op_e  req_op;
    logic     resp_valid;
    logic     resp_ready;
    data_t    resp_rdata;
    logic     resp_err;
    gpio_t    gpio_in;
    gpio_t    gpio_out;
    gpio_t    gpio_en;

    // Parsed vectors with one entry per command line
    logic [7:0]  cmd_q[$];
    logic [31:0] f0_q[$];
    logic [31:0] f1_q[$];
    logic [31:0] f2_q[$];
    logic [31:0] f3_q[$];

    logic [31:0] ram_model [DMEM_WORDS];
    integer      seed;
    int          value_errors;
    int          other_errors;
    int          n_lines;
    logic        parse_done;

    soc_top soc_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_write_i  (req_write),
        .req_op_i     (req_op),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_rdata_o (resp_rdata),
        .resp_err_o   (resp_err),
        .gpio_i       (gpio_in),
        .gpio_o       (gpio_out),
        .gpio_en_o    (gpio_en)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ====================
    // Checks and helpers
    // ====================

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic print_error_counts();
        $display("Error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    // Expected error from the address map and alignment rules
    function automatic logic access_fails(input logic [31:0] addr, input logic [2:0] op);
        logic mapped;
        logic misaligned;
        mapped = (addr < DMEM_BASE + DMEM_WORDS * 4)
              || (addr >= GPIO_BASE && addr < GPIO_BASE + 16)
              || (addr >= PWM_BASE && addr < PWM_BASE + 16);
        case (op)
            3'b001, 3'b101: misaligned = addr[0];
            3'b010:         misaligned = |addr[1:0];
            default:        misaligned = 1'b0;
        endcase
        return misaligned || !mapped;
    endfunction

    task automatic read_vectors();
        int          fd;
        int          code;
        logic [7:0]  c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] e;
        logic [8*128-1:0] rest;
        fd = $fopen("sim/soc_tb_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the input vector file");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", c);
            if (code == 1) begin
                n_lines++;
                a = '0;
                b = '0;
                d = '0;
                e = '0;
                if (c == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    case (c)
                        "W":      code = $fscanf(fd, "%h %h %h", a, b, d);
                        "R":      code = $fscanf(fd, "%h %h %h %h", a, b, d, e);
                        "X", "C": code = $fscanf(fd, "%h %h", a, b);
                        default:  code = $fscanf(fd, "%h", a);
                    endcase
                    cmd_q.push_back(c);
                    f0_q.push_back(a);
                    f1_q.push_back(b);
                    f2_q.push_back(d);
                    f3_q.push_back(e);
                end
            end
        end
        $fclose(fd);
        if (cmd_q.size() == 0) begin
            other_errors++;
            $display("The input vector file holds no commands");
        end else begin
            parse_done = 1'b1;
        end
    endtask

    // ====================
    // Bus access tasks
    // ====================

    // Issue one request, wait for the response and optionally hold it
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic write, input logic [2:0] op, input int hold,
                              output logic [31:0] rdata, output logic err);
        logic [31:0] held_data;
        logic        held_err;
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b1;
        req_addr  = addr;
        req_wdata = wdata;
        req_write = write;
        req_op    = mem_op_e'(op);
        while (!req_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b0;
        while (!resp_valid) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        held_data = resp_rdata;
        held_err  = resp_err;
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_value("held valid", 1, resp_valid);
            check_value("held ready", 0, req_ready);
            check_value("held rdata", held_data, resp_rdata);
            check_value("held err", held_err, resp_err);
        end
        resp_ready = 1'b1;
        rdata      = resp_rdata;
        err        = resp_err;
        @(posedge clk);
        #DRIVE_DLY;
        resp_ready = 1'b0;
    endtask

    task automatic store_access(input logic [31:0] addr, input logic [31:0] data,
                                input logic [2:0] op);
        logic [31:0] rdata;
        logic        err;
        bus_access(addr, data, 1'b1, op, 0, rdata, err);
        check_value($sformatf("store err %h", addr), access_fails(addr, op), err);
        check_value($sformatf("store rdata %h", addr), 32'h0, rdata);
    endtask

    task automatic load_check(input logic [31:0] addr, input logic [2:0] op,
                              input logic [31:0] exp_data, input logic exp_err,
                              input int hold);
        logic [31:0] rdata;
        logic        err;
        bus_access(addr, 32'h0, 1'b0, op, hold, rdata, err);
        check_value($sformatf("load data %h", addr), exp_data, rdata);
        check_value($sformatf("load err %h", addr), exp_err, err);
    endtask

    // Two-flop sync plus input register needs more than three edges
    task automatic drive_pins(input logic [31:0] value);
        @(posedge clk);
        #DRIVE_DLY;
        gpio_in = value[GPIO_PINS-1:0];
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_pins(input logic [31:0] out_exp, input logic [31:0] en_exp);
        check_value("pin out", out_exp[GPIO_PINS-1:0], gpio_out);
        check_value("pin enable", en_exp[GPIO_PINS-1:0], gpio_en);
    endtask

    task automatic count_pwm_high(input int cycles, input int exp_high);
        int   high;
        logic en_ok;
        high  = 0;
        en_ok = 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (gpio_out[PWM_PIN]) begin
                high++;
            end
            en_ok = en_ok & gpio_en[PWM_PIN];
        end
        check_value("pwm high count", exp_high, high);
        assert (en_ok) else begin
            other_errors++;
            $display("PWM pad enable dropped during the count");
        end
    endtask

    // Random word writes followed by read back under random back-pressure
    task automatic random_fill(input int count);
        logic [31:0] addrs[$];
        logic [31:0] addr;
        logic [31:0] data;
        int          hold;
        for (int i = 0; i < count; i++) begin
            addr = $random(seed) & 32'h0000_0FFC;
            data = $random(seed);
            store_access(addr, data, 3'b010);
            ram_model[addr[11:2]] = data;
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            hold = $random(seed) & 3;
            load_check(addrs[i], 3'b010, ram_model[addrs[i][11:2]], 1'b0, hold);
        end
    endtask

    // ====================
    // Watchdog
    // ====================

    initial begin
        wait (parse_done);
        #(n_lines * 200 * CLK_PERIOD);
        other_errors++;
        $display("Watchdog expired before the vectors completed");
        print_error_counts();
        $display("Simulation failed");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================

    initial begin
        seed         = 54922;
        clk          = 1'b0;
        reset_n      = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_write    = 1'b0;
        req_op       = MEM_W;
        resp_ready   = 1'b0;
        gpio_in      = '0;
        value_errors = 0;
        other_errors = 0;
        n_lines      = 0;
        parse_done   = 1'b0;
        read_vectors();
        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;
        check_value("reset ready", 1, req_ready);
        check_value("reset valid", 0, resp_valid);
        check_value("reset pin enable", 0, gpio_en);
        check_value("reset pin out", 0, gpio_out);
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "W": store_access(f0_q[i], f1_q[i], f2_q[i][2:0]);
                "R": load_check(f0_q[i], f1_q[i][2:0], f2_q[i], f3_q[i][0], 0);
                "D": drive_pins(f0_q[i]);
                "X": check_pins(f0_q[i], f1_q[i]);
                "C": count_pwm_high(f0_q[i], f1_q[i]);
                "F": random_fill(f0_q[i]);
                default: begin
                    other_errors++;
                    $display("Unknown command code %h in the vector file", cmd_q[i]);
                end
            endcase
        end
        print_error_counts();
        if (value_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : soc_tb

/* compile.f */
verilog/soc_pkg.sv
verilog/bus_master.sv
verilog/bus_decoder.sv
verilog/data_ram.sv
verilog/gpio_ctrl.sv
verilog/pwm_timer.sv
verilog/soc_top.sv
sim/soc_tb.sv

/* sim/soc_tb_input.txt */
# Fields in hex: W addr data op | R addr op data err | D pins | X out en
# C cycles high_count | F count; op is the RISC-V funct3 width code
W 00000100 11223344 2
R 00000100 2 11223344 0
W 00000101 000000AA 0
R 00000100 2 1122AA44 0
R 00000101 0 FFFFFFAA 0
R 00000101 4 000000AA 0
W 00000102 0000BEEF 1
R 00000100 2 BEEFAA44 0
R 00000102 1 FFFFBEEF 0
R 00000102 5 0000BEEF 0
R 00000100 1 FFFFAA44 0
R 00000103 0 FFFFFFBE 0
W 00000200 7FFF0055 2
R 00000200 5 00000055 0
R 00000202 1 00007FFF 0
R 00000203 0 0000007F 0
# Unmapped and misaligned accesses
R 30000000 2 00000000 1
R 00000101 1 00000000 1
R 00000102 2 00000000 1
W 00000102 DEADBEEF 2
W 00000203 000000EE 1
W 20000020 00000001 2
R 00000100 2 BEEFAA44 0
R 00000200 2 7FFF0055 0
# GPIO output and input
W 20000000 000000A5 2
W 20000004 0000000F 2
X A5 0F
R 20000004 2 0000000F 0
D 3C
R 20000008 2 0000003C 0
W 20000008 000000FF 2
R 20000008 2 0000003C 0
# PWM on pad 7
W 20000100 0000000A 2
W 20000104 00000003 2
W 20000108 00000001 2
W 2000000C 00000001 2
C 1E 9
C 14 6
W 20000108 00000000 2
X 25 8F
R 2000010C 2 00000000 0
F 20
